// File: verilog/mipsIsaPkg.sv
package mipsIsaPkg;
	typedef logic [31:0] word_t;
	typedef logic [4:0] regAddr_t;
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;

	// primary opcodes
	localparam opcode_t opRType = 6'b000000;
	localparam opcode_t opRegimm = 6'b000001;
	localparam opcode_t opJ = 6'b000010;
	localparam opcode_t opJal = 6'b000011;
	localparam opcode_t opBeq = 6'b000100;
	localparam opcode_t opBne = 6'b000101;
	localparam opcode_t opBlez = 6'b000110;
	localparam opcode_t opBgtz = 6'b000111;
	localparam opcode_t opAddi = 6'b001000;
	localparam opcode_t opAddiu = 6'b001001;
	localparam opcode_t opSlti = 6'b001010;
	localparam opcode_t opSltiu = 6'b001011;
	localparam opcode_t opAndi = 6'b001100;
	localparam opcode_t opOri = 6'b001101;
	localparam opcode_t opXori = 6'b001110;
	localparam opcode_t opLui = 6'b001111;
	localparam opcode_t opCop0 = 6'b010000;
	localparam opcode_t opSpecial2 = 6'b011100;
	localparam opcode_t opSpecial3 = 6'b011111;
	localparam opcode_t opLb = 6'b100000;
	localparam opcode_t opLh = 6'b100001;
	localparam opcode_t opLw = 6'b100011;
	localparam opcode_t opLbu = 6'b100100;
	localparam opcode_t opLhu = 6'b100101;
	localparam opcode_t opSb = 6'b101000;
	localparam opcode_t opSh = 6'b101001;
	localparam opcode_t opSw = 6'b101011;

	// R-type functs
	localparam funct_t fnSll = 6'b000000;
	localparam funct_t fnSrl = 6'b000010; // also ROTR
	localparam funct_t fnSra = 6'b000011;
	localparam funct_t fnSllv = 6'b000100;
	localparam funct_t fnSrlv = 6'b000110; // also ROTRV
	localparam funct_t fnSrav = 6'b000111;
	localparam funct_t fnJr = 6'b001000;
	localparam funct_t fnJalr = 6'b001001;
	localparam funct_t fnMovz = 6'b001010;
	localparam funct_t fnMovn = 6'b001011;
	localparam funct_t fnSyscall = 6'b001100;
	localparam funct_t fnBreak = 6'b001101;
	localparam funct_t fnMfhi = 6'b010000;
	localparam funct_t fnMthi = 6'b010001;
	localparam funct_t fnMflo = 6'b010010;
	localparam funct_t fnMtlo = 6'b010011;
	localparam funct_t fnMult = 6'b011000;
	localparam funct_t fnMultu = 6'b011001;
	localparam funct_t fnDiv = 6'b011010;
	localparam funct_t fnDivu = 6'b011011;
	localparam funct_t fnAdd = 6'b100000;
	localparam funct_t fnAddu = 6'b100001;
	localparam funct_t fnSub = 6'b100010;
	localparam funct_t fnSubu = 6'b100011;
	localparam funct_t fnAnd = 6'b100100;
	localparam funct_t fnOr = 6'b100101;
	localparam funct_t fnXor = 6'b100110;
	localparam funct_t fnNor = 6'b100111;
	localparam funct_t fnSlt = 6'b101010;
	localparam funct_t fnSltu = 6'b101011;
	localparam funct_t fnTge = 6'b110000;
	localparam funct_t fnTgeu = 6'b110001;
	localparam funct_t fnTlt = 6'b110010;
	localparam funct_t fnTltu = 6'b110011;
	localparam funct_t fnTeq = 6'b110100;
	localparam funct_t fnTne = 6'b110110;

	// SPECIAL2 functs
	localparam funct_t fnMadd = 6'b000000;
	localparam funct_t fnMaddu = 6'b000001;
	localparam funct_t fnMul = 6'b000010;
	localparam funct_t fnMsub = 6'b000100;
	localparam funct_t fnMsubu = 6'b000101;
	localparam funct_t fnClz = 6'b100000;
	localparam funct_t fnClo = 6'b100001;

	// SPECIAL3 functs
	localparam funct_t fnExt = 6'b000000;
	localparam funct_t fnIns = 6'b000100;
	localparam funct_t fnBshfl = 6'b100000; // op picked by the sa field
	localparam logic [4:0] saWsbh = 5'b00010;
	localparam logic [4:0] saSeb = 5'b10000;
	localparam logic [4:0] saSeh = 5'b11000;

	// REGIMM rt codes
	localparam logic [4:0] rtBltz = 5'b00000;
	localparam logic [4:0] rtBgez = 5'b00001;
	localparam logic [4:0] rtTgei = 5'b01000;
	localparam logic [4:0] rtTgeiu = 5'b01001;
	localparam logic [4:0] rtTlti = 5'b01010;
	localparam logic [4:0] rtTltiu = 5'b01011;
	localparam logic [4:0] rtTeqi = 5'b01100;
	localparam logic [4:0] rtTnei = 5'b01110;
	localparam logic [4:0] rtBltzal = 5'b10000;
	localparam logic [4:0] rtBgezal = 5'b10001;

	// COP0 rs codes
	localparam logic [4:0] rsMfc0 = 5'b00000;
	localparam logic [4:0] rsMtc0 = 5'b00100;
	localparam logic [4:0] rsCo = 5'b10000;
	localparam funct_t fnEret = 6'b011000; // funct under rsCo
endpackage

// File: verilog/decodeCtrlPkg.sv
package decodeCtrlPkg;
	typedef logic [5:0] aluOp_t;
	typedef logic [2:0] branchCond_t;
	typedef logic [1:0] jumpKind_t;
	typedef logic [1:0] regDst_t;

	localparam aluOp_t aluRType = 6'd0; // execute decodes functToAlu
	localparam aluOp_t aluAddi = 6'd1;
	localparam aluOp_t aluAddiu = 6'd2;
	localparam aluOp_t aluSlti = 6'd3;
	localparam aluOp_t aluSltiu = 6'd4;
	localparam aluOp_t aluAndi = 6'd5;
	localparam aluOp_t aluOri = 6'd6;
	localparam aluOp_t aluXori = 6'd7;
	localparam aluOp_t aluLui = 6'd8;
	localparam aluOp_t aluMem = 6'd9;
	localparam aluOp_t aluTeqi = 6'd10;
	localparam aluOp_t aluTgei = 6'd11;
	localparam aluOp_t aluTgeiu = 6'd12;
	localparam aluOp_t aluTlti = 6'd13;
	localparam aluOp_t aluTltiu = 6'd14;
	localparam aluOp_t aluTnei = 6'd15;
	localparam aluOp_t aluRotr = 6'd16;
	localparam aluOp_t aluRotrv = 6'd17;
	localparam aluOp_t aluMul = 6'd18;
	// unsigned madd/msub told apart by functToAlu[0]
	localparam aluOp_t aluMadd = 6'd19;
	localparam aluOp_t aluMsub = 6'd20;
	localparam aluOp_t aluClo = 6'd21;
	localparam aluOp_t aluClz = 6'd22;
	localparam aluOp_t aluSeb = 6'd23;
	localparam aluOp_t aluSeh = 6'd24;
	localparam aluOp_t aluWsbh = 6'd25;
	localparam aluOp_t aluExt = 6'd26;
	localparam aluOp_t aluIns = 6'd27;
	localparam aluOp_t aluMtc0 = 6'd28;
	localparam aluOp_t aluMfc0 = 6'd29;
	localparam aluOp_t aluUseless = 6'd63;

	localparam branchCond_t brNone = 3'd0;
	localparam branchCond_t brEq = 3'd1;
	localparam branchCond_t brNe = 3'd2;
	localparam branchCond_t brLez = 3'd3;
	localparam branchCond_t brGtz = 3'd4;
	localparam branchCond_t brLtz = 3'd5;
	localparam branchCond_t brGez = 3'd6;

	localparam jumpKind_t jmpNone = 2'd0;
	localparam jumpKind_t jmpDirect = 2'd1;
	localparam jumpKind_t jmpReg = 2'd2;

	localparam regDst_t dstRd = 2'd0;
	localparam regDst_t dstRt = 2'd1;
	localparam regDst_t dstRa = 2'd2; // link writes r31

	typedef struct packed {
		logic regWrite;
		regDst_t regDst;
		logic isImm; // alu srcB is the immediate
		logic memRead;
		logic memWrite;
		logic memToReg;
		logic signExt;
		logic hiloToReg;
		logic mfhi;
		logic mflo;
		logic isMfc;
		logic cp0Write;
		logic cp0ToReg;
		logic divMulEn;
		aluOp_t aluOp;
		mipsIsaPkg::funct_t functToAlu;
		branchCond_t branchCond;
		jumpKind_t jumpKind;
	} decodeCtrl_t;

	typedef struct packed {
		logic ri;
		logic brk;
		logic syscall;
		logic eret;
	} excFlags_t;

	typedef struct packed {
		logic valid;
		decodeCtrl_t ctrl;
		excFlags_t exc;
		mipsIsaPkg::word_t pcPlus4;
		mipsIsaPkg::word_t rsData;
		mipsIsaPkg::word_t rtData;
		mipsIsaPkg::word_t imm;
		mipsIsaPkg::regAddr_t rs;
		mipsIsaPkg::regAddr_t rt;
		mipsIsaPkg::regAddr_t rd;
	} idExBundle_t;
endpackage

// File: verilog/mainDecoder.sv
`timescale 1ns/10ps

module mainDecoder (
	input  mipsIsaPkg::word_t instr,
	output decodeCtrlPkg::decodeCtrl_t ctrl,
	output decodeCtrlPkg::excFlags_t exc
);
	mipsIsaPkg::opcode_t op;
	mipsIsaPkg::funct_t fn;
	logic [4:0] rs;
	logic [4:0] rt;
	logic [4:0] sa;
	logic isEret;

	assign op = instr[31:26];
	assign fn = instr[5:0];
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign sa = instr[10:6];

	// eret has to match all 26 low bits
	assign isEret = (op == mipsIsaPkg::opCop0) &&
		(instr[25:0] == {mipsIsaPkg::rsCo, 15'd0, mipsIsaPkg::fnEret});

	always_comb begin
		ctrl = '0;
		exc = '0;
		ctrl.functToAlu = fn;
		ctrl.signExt = (op[5:2] != 4'b0011); // andi/ori/xori/lui zero extend
		ctrl.aluOp = decodeCtrlPkg::aluUseless;
		case (op)
			mipsIsaPkg::opRType: begin
				ctrl.aluOp = decodeCtrlPkg::aluRType;
				case (fn)
					mipsIsaPkg::fnAdd, mipsIsaPkg::fnAddu, mipsIsaPkg::fnSub, mipsIsaPkg::fnSubu,
					mipsIsaPkg::fnAnd, mipsIsaPkg::fnOr, mipsIsaPkg::fnXor, mipsIsaPkg::fnNor,
					mipsIsaPkg::fnSlt, mipsIsaPkg::fnSltu, mipsIsaPkg::fnSll, mipsIsaPkg::fnSra,
					mipsIsaPkg::fnSllv, mipsIsaPkg::fnSrav, mipsIsaPkg::fnMovn, mipsIsaPkg::fnMovz:
						ctrl.regWrite = 1'b1;
					mipsIsaPkg::fnSrl: begin
						ctrl.regWrite = 1'b1;
						if (instr[21]) // R bit in the rs field
							ctrl.aluOp = decodeCtrlPkg::aluRotr;
					end
					mipsIsaPkg::fnSrlv: begin
						ctrl.regWrite = 1'b1;
						if (instr[6]) // R bit in the sa field
							ctrl.aluOp = decodeCtrlPkg::aluRotrv;
					end
					mipsIsaPkg::fnMfhi, mipsIsaPkg::fnMflo: begin
						ctrl.regWrite = 1'b1;
						ctrl.hiloToReg = 1'b1;
						ctrl.mfhi = ~fn[1];
						ctrl.mflo = fn[1];
					end
					mipsIsaPkg::fnMult, mipsIsaPkg::fnMultu, mipsIsaPkg::fnDiv, mipsIsaPkg::fnDivu:
						ctrl.divMulEn = 1'b1;
					mipsIsaPkg::fnJr:
						ctrl.jumpKind = decodeCtrlPkg::jmpReg;
					mipsIsaPkg::fnJalr: begin
						ctrl.regWrite = 1'b1;
						ctrl.jumpKind = decodeCtrlPkg::jmpReg;
					end
					mipsIsaPkg::fnSyscall: exc.syscall = 1'b1;
					mipsIsaPkg::fnBreak: exc.brk = 1'b1;
					// hilo moves and traps use no register write
					mipsIsaPkg::fnMthi, mipsIsaPkg::fnMtlo, mipsIsaPkg::fnTge, mipsIsaPkg::fnTgeu,
					mipsIsaPkg::fnTlt, mipsIsaPkg::fnTltu, mipsIsaPkg::fnTeq, mipsIsaPkg::fnTne: ;
					default: begin
						exc.ri = 1'b1;
						ctrl.aluOp = decodeCtrlPkg::aluUseless;
					end
				endcase
			end
			mipsIsaPkg::opAddi, mipsIsaPkg::opAddiu, mipsIsaPkg::opSlti, mipsIsaPkg::opSltiu,
			mipsIsaPkg::opAndi, mipsIsaPkg::opOri, mipsIsaPkg::opXori, mipsIsaPkg::opLui: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = decodeCtrlPkg::dstRt;
				ctrl.isImm = 1'b1;
				case (op)
					mipsIsaPkg::opAddi: ctrl.aluOp = decodeCtrlPkg::aluAddi;
					mipsIsaPkg::opAddiu: ctrl.aluOp = decodeCtrlPkg::aluAddiu;
					mipsIsaPkg::opSlti: ctrl.aluOp = decodeCtrlPkg::aluSlti;
					mipsIsaPkg::opSltiu: ctrl.aluOp = decodeCtrlPkg::aluSltiu;
					mipsIsaPkg::opAndi: ctrl.aluOp = decodeCtrlPkg::aluAndi;
					mipsIsaPkg::opOri: ctrl.aluOp = decodeCtrlPkg::aluOri;
					mipsIsaPkg::opXori: ctrl.aluOp = decodeCtrlPkg::aluXori;
					default: ctrl.aluOp = decodeCtrlPkg::aluLui;
				endcase
			end
			mipsIsaPkg::opBeq: ctrl.branchCond = decodeCtrlPkg::brEq;
			mipsIsaPkg::opBne: ctrl.branchCond = decodeCtrlPkg::brNe;
			mipsIsaPkg::opBlez: ctrl.branchCond = decodeCtrlPkg::brLez;
			mipsIsaPkg::opBgtz: ctrl.branchCond = decodeCtrlPkg::brGtz;
			mipsIsaPkg::opRegimm: begin
				case (rt)
					mipsIsaPkg::rtBltz, mipsIsaPkg::rtBgez,
					mipsIsaPkg::rtBltzal, mipsIsaPkg::rtBgezal: begin
						ctrl.branchCond = rt[0] ? decodeCtrlPkg::brGez : decodeCtrlPkg::brLtz;
						if (rt[4]) begin // link forms
							ctrl.regWrite = 1'b1;
							ctrl.regDst = decodeCtrlPkg::dstRa;
						end
					end
					mipsIsaPkg::rtTeqi: ctrl.aluOp = decodeCtrlPkg::aluTeqi;
					mipsIsaPkg::rtTgei: ctrl.aluOp = decodeCtrlPkg::aluTgei;
					mipsIsaPkg::rtTgeiu: ctrl.aluOp = decodeCtrlPkg::aluTgeiu;
					mipsIsaPkg::rtTlti: ctrl.aluOp = decodeCtrlPkg::aluTlti;
					mipsIsaPkg::rtTltiu: ctrl.aluOp = decodeCtrlPkg::aluTltiu;
					mipsIsaPkg::rtTnei: ctrl.aluOp = decodeCtrlPkg::aluTnei;
					default: exc.ri = 1'b1;
				endcase
				ctrl.isImm = (rt[4:3] == 2'b01); // trap-immediate compare
			end
			mipsIsaPkg::opLb, mipsIsaPkg::opLh, mipsIsaPkg::opLw,
			mipsIsaPkg::opLbu, mipsIsaPkg::opLhu: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = decodeCtrlPkg::dstRt;
				ctrl.isImm = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluOp = decodeCtrlPkg::aluMem;
			end
			mipsIsaPkg::opSb, mipsIsaPkg::opSh, mipsIsaPkg::opSw: begin
				ctrl.isImm = 1'b1;
				ctrl.memWrite = 1'b1;
				ctrl.aluOp = decodeCtrlPkg::aluMem;
			end
			mipsIsaPkg::opJ: ctrl.jumpKind = decodeCtrlPkg::jmpDirect;
			mipsIsaPkg::opJal: begin
				ctrl.jumpKind = decodeCtrlPkg::jmpDirect;
				ctrl.regWrite = 1'b1;
				ctrl.regDst = decodeCtrlPkg::dstRa;
			end
			mipsIsaPkg::opCop0: begin
				case (rs)
					mipsIsaPkg::rsMtc0: begin
						ctrl.cp0Write = 1'b1;
						ctrl.aluOp = decodeCtrlPkg::aluMtc0;
					end
					mipsIsaPkg::rsMfc0: begin
						ctrl.regWrite = 1'b1;
						ctrl.regDst = decodeCtrlPkg::dstRt;
						ctrl.isMfc = 1'b1;
						ctrl.cp0ToReg = 1'b1;
						ctrl.aluOp = decodeCtrlPkg::aluMfc0;
					end
					default: begin
						exc.eret = isEret;
						exc.ri = ~isEret;
					end
				endcase
			end
			mipsIsaPkg::opSpecial2: begin
				case (fn)
					mipsIsaPkg::fnClo, mipsIsaPkg::fnClz: begin
						ctrl.regWrite = 1'b1;
						ctrl.aluOp = fn[0] ? decodeCtrlPkg::aluClo : decodeCtrlPkg::aluClz;
					end
					mipsIsaPkg::fnMul: begin
						ctrl.regWrite = 1'b1;
						ctrl.divMulEn = 1'b1;
						ctrl.aluOp = decodeCtrlPkg::aluMul;
					end
					mipsIsaPkg::fnMadd, mipsIsaPkg::fnMaddu: begin
						ctrl.divMulEn = 1'b1;
						ctrl.aluOp = decodeCtrlPkg::aluMadd;
					end
					mipsIsaPkg::fnMsub, mipsIsaPkg::fnMsubu: begin
						ctrl.divMulEn = 1'b1;
						ctrl.aluOp = decodeCtrlPkg::aluMsub;
					end
					default: exc.ri = 1'b1;
				endcase
			end
			mipsIsaPkg::opSpecial3: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = decodeCtrlPkg::dstRt; // ext/ins write rt
				case (fn)
					mipsIsaPkg::fnExt: ctrl.aluOp = decodeCtrlPkg::aluExt;
					mipsIsaPkg::fnIns: ctrl.aluOp = decodeCtrlPkg::aluIns;
					mipsIsaPkg::fnBshfl: begin
						ctrl.regDst = decodeCtrlPkg::dstRd;
						case (sa)
							mipsIsaPkg::saSeb: ctrl.aluOp = decodeCtrlPkg::aluSeb;
							mipsIsaPkg::saSeh: ctrl.aluOp = decodeCtrlPkg::aluSeh;
							mipsIsaPkg::saWsbh: ctrl.aluOp = decodeCtrlPkg::aluWsbh;
							default: exc.ri = 1'b1;
						endcase
					end
					default: exc.ri = 1'b1;
				endcase
				if (exc.ri)
					ctrl.regWrite = 1'b0;
			end
			default: exc.ri = 1'b1;
		endcase
	end
endmodule

// File: verilog/regFile.sv
`timescale 1ns/10ps

module regFile (
	input  logic clk,
	input  logic arstN,
	input  logic we,
	input  mipsIsaPkg::regAddr_t wAddr,
	input  mipsIsaPkg::word_t wData,
	input  mipsIsaPkg::regAddr_t rAddr0,
	input  mipsIsaPkg::regAddr_t rAddr1,
	output mipsIsaPkg::word_t rData0,
	output mipsIsaPkg::word_t rData1
);
	mipsIsaPkg::word_t mem [1:31]; // r0 has no storage
	logic wrEn;

	// no write-back while the core is held in reset
	assign wrEn = we && arstN && (wAddr != '0);

	always_ff @(posedge clk) begin
		if (wrEn)
			mem[wAddr] <= wData;
	end

	// same-cycle bypass from write-back
	assign rData0 = (wrEn && rAddr0 == wAddr) ? wData :
		(rAddr0 == '0) ? '0 : mem[rAddr0];
	assign rData1 = (wrEn && rAddr1 == wAddr) ? wData :
		(rAddr1 == '0) ? '0 : mem[rAddr1];
endmodule

// File: verilog/branchResolver.sv
`timescale 1ns/10ps

module branchResolver (
	input  logic valid,
	input  decodeCtrlPkg::branchCond_t cond,
	input  decodeCtrlPkg::jumpKind_t jump,
	input  mipsIsaPkg::word_t rsVal,
	input  mipsIsaPkg::word_t rtVal,
	input  mipsIsaPkg::word_t pcPlus4,
	input  logic [25:0] instrIndex,
	output logic taken,
	output mipsIsaPkg::word_t target
);
	logic eq;
	logic rsNeg;
	logic rsZero;
	logic condMet;
	mipsIsaPkg::word_t brOffset;

	assign eq = (rsVal == rtVal);
	assign rsNeg = rsVal[31];
	assign rsZero = (rsVal == '0);

	// low half of the index field is the branch immediate
	assign brOffset = {{14{instrIndex[15]}}, instrIndex[15:0], 2'b00};

	always_comb begin
		case (cond)
			decodeCtrlPkg::brEq: condMet = eq;
			decodeCtrlPkg::brNe: condMet = ~eq;
			decodeCtrlPkg::brLez: condMet = rsNeg | rsZero;
			decodeCtrlPkg::brGtz: condMet = ~rsNeg & ~rsZero;
			decodeCtrlPkg::brLtz: condMet = rsNeg;
			decodeCtrlPkg::brGez: condMet = ~rsNeg;
			default: condMet = 1'b0;
		endcase
	end

	assign taken = valid && (condMet || jump != decodeCtrlPkg::jmpNone);

	always_comb begin
		case (jump)
			decodeCtrlPkg::jmpDirect: target = {pcPlus4[31:28], instrIndex, 2'b00};
			decodeCtrlPkg::jmpReg: target = rsVal;
			default: target = pcPlus4 + brOffset;
		endcase
	end
endmodule

// File: verilog/decodeStage.sv
`timescale 1ns/10ps

module decodeStage #(
	parameter mipsIsaPkg::word_t RESET_PC_PLUS4 = 32'hbfc0_0004 // boot vector + 4
) (
	input  logic clk,
	input  logic arstN,
	input  logic validIn,
	input  mipsIsaPkg::word_t instr,
	input  mipsIsaPkg::word_t pcPlus4,
	input  logic stall,
	input  logic flush,
	input  logic wbWe,
	input  mipsIsaPkg::regAddr_t wbAddr,
	input  mipsIsaPkg::word_t wbData,
	output logic branchTaken,
	output mipsIsaPkg::word_t branchTarget,
	output decodeCtrlPkg::idExBundle_t idEx
);
	decodeCtrlPkg::decodeCtrl_t ctrl;
	decodeCtrlPkg::excFlags_t exc;
	mipsIsaPkg::regAddr_t rs;
	mipsIsaPkg::regAddr_t rt;
	mipsIsaPkg::regAddr_t rd;
	mipsIsaPkg::word_t rsData;
	mipsIsaPkg::word_t rtData;
	mipsIsaPkg::word_t imm;
	decodeCtrlPkg::idExBundle_t idExNext;
	decodeCtrlPkg::idExBundle_t bubble;

	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];
	assign imm = ctrl.signExt ? {{16{instr[15]}}, instr[15:0]} : {16'd0, instr[15:0]};

	mainDecoder mainDecoder0 (
		.instr(instr),
		.ctrl(ctrl),
		.exc(exc)
	);

	regFile regFile0 (
		.clk(clk),
		.arstN(arstN),
		.we(wbWe),
		.wAddr(wbAddr),
		.wData(wbData),
		.rAddr0(rs),
		.rAddr1(rt),
		.rData0(rsData),
		.rData1(rtData)
	);

	branchResolver branchResolver0 (
		.valid(validIn),
		.cond(ctrl.branchCond),
		.jump(ctrl.jumpKind),
		.rsVal(rsData),
		.rtVal(rtData),
		.pcPlus4(pcPlus4),
		.instrIndex(instr[25:0]),
		.taken(branchTaken),
		.target(branchTarget)
	);

	always_comb begin
		idExNext.valid = validIn;
		idExNext.ctrl = ctrl;
		idExNext.exc = exc;
		idExNext.pcPlus4 = pcPlus4;
		idExNext.rsData = rsData;
		idExNext.rtData = rtData;
		idExNext.imm = imm;
		idExNext.rs = rs;
		idExNext.rt = rt;
		idExNext.rd = rd;
		// bubble keeps the payload, kills everything that acts
		bubble = idExNext;
		bubble.valid = 1'b0;
		bubble.ctrl = '0;
		bubble.exc = '0;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			idEx <= '0;
			idEx.pcPlus4 <= RESET_PC_PLUS4;
		end else if (flush) begin
			idEx <= bubble;
		end else if (!stall) begin
			idEx <= validIn ? idExNext : bubble;
		end
	end
endmodule

// File: dv/decodeStage_asserts.sv
`timescale 1ns/10ps

module decodeStage_asserts (
	input logic clk,
	input logic arstN,
	input logic flush,
	input logic stall,
	input decodeCtrlPkg::idExBundle_t idEx
);
	// a flushed slot never reaches execute as valid
	flushBubble: assert property (@(posedge clk) disable iff (!arstN)
		flush |=> !idEx.valid)
		else $error("idEx.valid set in the cycle after a flush");

	memExclusive: assert property (@(posedge clk) disable iff (!arstN)
		!(idEx.ctrl.memRead && idEx.ctrl.memWrite))
		else $error("memRead and memWrite both set in idEx");

	stallHold: assert property (@(posedge clk) disable iff (!arstN)
		stall && !flush |=> $stable(idEx))
		else $error("idEx changed during a stall");
endmodule

bind decodeStage decodeStage_asserts asserts0 (
	.clk(clk),
	.arstN(arstN),
	.flush(flush),
	.stall(stall),
	.idEx(idEx)
);

// File: dv/decodeStageTb.sv
`timescale 1ns/10ps

module decodeStageTb;
	localparam mipsIsaPkg::word_t resetPc = 32'h1fc0_0004;
	localparam int maxCycles = 400; // several times the length of all tests

	logic clk;
	logic arstN;
	logic validIn;
	mipsIsaPkg::word_t instr;
	mipsIsaPkg::word_t pcPlus4;
	logic stall;
	logic flush;
	logic wbWe;
	mipsIsaPkg::regAddr_t wbAddr;
	mipsIsaPkg::word_t wbData;
	logic branchTaken;
	mipsIsaPkg::word_t branchTarget;
	decodeCtrlPkg::idExBundle_t idEx;

	mipsIsaPkg::word_t regVal [0:31]; // last value written per register
	string testName = "none";
	int seed;
	int cycles = 0;

	decodeStage #(.RESET_PC_PLUS4(resetPc)) dut0 (
		.clk(clk),
		.arstN(arstN),
		.validIn(validIn),
		.instr(instr),
		.pcPlus4(pcPlus4),
		.stall(stall),
		.flush(flush),
		.wbWe(wbWe),
		.wbAddr(wbAddr),
		.wbData(wbData),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.idEx(idEx)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic failRun();
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == maxCycles) begin
			$display("timeout: the tests did not finish within %0d cycles", maxCycles);
			failRun();
		end
	end

	task automatic checkCtrl(input string what, input decodeCtrlPkg::decodeCtrl_t exp,
		input decodeCtrlPkg::decodeCtrl_t act);
		if (act !== exp) begin
			$display("error %s %s: expected %h, actual %h", testName, what, exp, act);
			failRun();
		end
	endtask

	task automatic checkExc(input string what, input decodeCtrlPkg::excFlags_t exp,
		input decodeCtrlPkg::excFlags_t act);
		if (act !== exp) begin
			$display("error %s %s: expected %b, actual %b", testName, what, exp, act);
			failRun();
		end
	endtask

	task automatic checkWord(input string what, input mipsIsaPkg::word_t exp,
		input mipsIsaPkg::word_t act);
		if (act !== exp) begin
			$display("error %s %s: expected %h, actual %h", testName, what, exp, act);
			failRun();
		end
	endtask

	task automatic checkAddr(input string what, input mipsIsaPkg::regAddr_t exp,
		input mipsIsaPkg::regAddr_t act);
		if (act !== exp) begin
			$display("error %s %s: expected %0d, actual %0d", testName, what, exp, act);
			failRun();
		end
	endtask

	task automatic checkBit(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			$display("error %s %s: expected %b, actual %b", testName, what, exp, act);
			failRun();
		end
	endtask

	function automatic mipsIsaPkg::word_t rInstr(input mipsIsaPkg::opcode_t op,
		input mipsIsaPkg::regAddr_t rs, input mipsIsaPkg::regAddr_t rt,
		input mipsIsaPkg::regAddr_t rd, input logic [4:0] sa, input mipsIsaPkg::funct_t fn);
		return {op, rs, rt, rd, sa, fn};
	endfunction

	function automatic mipsIsaPkg::word_t iInstr(input mipsIsaPkg::opcode_t op,
		input mipsIsaPkg::regAddr_t rs, input mipsIsaPkg::regAddr_t rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic mipsIsaPkg::word_t jInstr(input mipsIsaPkg::opcode_t op,
		input logic [25:0] idx);
		return {op, idx};
	endfunction

	// pc+4 plus the word offset
	function automatic mipsIsaPkg::word_t brTarget(input mipsIsaPkg::word_t pc,
		input logic [15:0] off);
		return pc + 32'($signed(off)) * 32'd4;
	endfunction

	// 256 MB region of pc+4 with the word index inside it
	function automatic mipsIsaPkg::word_t jumpTarget(input mipsIsaPkg::word_t pc,
		input logic [25:0] idx);
		return (pc & 32'hf000_0000) | (32'(idx) << 2);
	endfunction

	// expected control word with all unnamed fields zero
	function automatic decodeCtrlPkg::decodeCtrl_t aluCtrl(input mipsIsaPkg::word_t ins,
		input logic se, input logic rw, input decodeCtrlPkg::regDst_t dst, input logic isImm,
		input decodeCtrlPkg::aluOp_t alu, input logic dm);
		decodeCtrlPkg::decodeCtrl_t c;
		c = '0;
		c.functToAlu = ins[5:0];
		c.signExt = se;
		c.regWrite = rw;
		c.regDst = dst;
		c.isImm = isImm;
		c.aluOp = alu;
		c.divMulEn = dm;
		return c;
	endfunction

	task automatic issue(input mipsIsaPkg::word_t ins, input mipsIsaPkg::word_t pc);
		@(posedge clk);
		validIn <= 1'b1;
		instr <= ins;
		pcPlus4 <= pc;
		@(negedge clk); // branch outputs settled
	endtask

	task automatic capture();
		@(posedge clk);
		@(negedge clk);
	endtask

	task automatic writeReg(input mipsIsaPkg::regAddr_t a, input mipsIsaPkg::word_t d);
		@(posedge clk);
		wbWe <= 1'b1;
		wbAddr <= a;
		wbData <= d;
		@(posedge clk);
		wbWe <= 1'b0;
		if (a != 5'd0)
			regVal[a] = d;
	endtask

	task automatic fillRegs();
		int i;
		regVal[0] = '0;
		for (i = 1; i < 32; i++) begin
			@(posedge clk);
			regVal[i] = $random(seed);
			wbWe <= 1'b1;
			wbAddr <= i[4:0];
			wbData <= regVal[i];
		end
		@(posedge clk);
		wbWe <= 1'b0;
	endtask

	task automatic decodeCheck(input mipsIsaPkg::word_t ins,
		input decodeCtrlPkg::decodeCtrl_t exp);
		issue(ins, 32'h0040_0104);
		capture();
		checkCtrl("ctrl", exp, idEx.ctrl);
		checkBit("valid", 1'b1, idEx.valid);
	endtask

	task automatic branchCheck(input mipsIsaPkg::word_t ins, input mipsIsaPkg::word_t pc,
		input logic taken, input mipsIsaPkg::word_t tgt);
		issue(ins, pc);
		checkBit("branchTaken", taken, branchTaken);
		if (taken)
			checkWord("branchTarget", tgt, branchTarget);
	endtask

	// flags are ri, brk, syscall, eret
	task automatic excCheck(input mipsIsaPkg::word_t ins, input decodeCtrlPkg::excFlags_t exp);
		issue(ins, 32'h0040_0400);
		capture();
		checkExc("exc", exp, idEx.exc);
	endtask

	task automatic checkBubble();
		checkBit("valid", 1'b0, idEx.valid);
		checkCtrl("bubble ctrl", '0, idEx.ctrl);
		checkExc("bubble exc", '0, idEx.exc);
	endtask

	task automatic resetTest();
		testName = "reset";
		checkBit("valid", 1'b0, idEx.valid);
		checkBit("regWrite", 1'b0, idEx.ctrl.regWrite);
		checkBit("memRead", 1'b0, idEx.ctrl.memRead);
		checkBit("memWrite", 1'b0, idEx.ctrl.memWrite);
		checkExc("exc", '0, idEx.exc);
		checkWord("pcPlus4", resetPc, idEx.pcPlus4);
	endtask

	task automatic aluDecodeTest();
		mipsIsaPkg::word_t ins;
		testName = "aluDecode";
		ins = rInstr(mipsIsaPkg::opRType, 5'd1, 5'd2, 5'd3, 5'd0, mipsIsaPkg::fnAddu);
		decodeCheck(ins, aluCtrl(ins, 1'b1, 1'b1, decodeCtrlPkg::dstRd, 1'b0,
			decodeCtrlPkg::aluRType, 1'b0));
		checkAddr("addu rs", 5'd1, idEx.rs);
		checkAddr("addu rt", 5'd2, idEx.rt);
		checkAddr("addu rd", 5'd3, idEx.rd);
		ins = iInstr(mipsIsaPkg::opAddi, 5'd1, 5'd4, 16'h8123);
		decodeCheck(ins, aluCtrl(ins, 1'b1, 1'b1, decodeCtrlPkg::dstRt, 1'b1,
			decodeCtrlPkg::aluAddi, 1'b0));
		checkWord("addi imm", 32'hffff_8123, idEx.imm);
		ins = iInstr(mipsIsaPkg::opOri, 5'd1, 5'd4, 16'h8123);
		decodeCheck(ins, aluCtrl(ins, 1'b0, 1'b1, decodeCtrlPkg::dstRt, 1'b1,
			decodeCtrlPkg::aluOri, 1'b0));
		checkWord("ori imm", 32'h0000_8123, idEx.imm);
		ins = iInstr(mipsIsaPkg::opLui, 5'd0, 5'd5, 16'h1234);
		decodeCheck(ins, aluCtrl(ins, 1'b0, 1'b1, decodeCtrlPkg::dstRt, 1'b1,
			decodeCtrlPkg::aluLui, 1'b0));
		ins = rInstr(mipsIsaPkg::opRType, 5'd0, 5'd2, 5'd3, 5'd4, mipsIsaPkg::fnSrl);
		decodeCheck(ins, aluCtrl(ins, 1'b1, 1'b1, decodeCtrlPkg::dstRd, 1'b0,
			decodeCtrlPkg::aluRType, 1'b0));
		ins = rInstr(mipsIsaPkg::opRType, 5'd1, 5'd2, 5'd3, 5'd4, mipsIsaPkg::fnSrl); // R bit set
		decodeCheck(ins, aluCtrl(ins, 1'b1, 1'b1, decodeCtrlPkg::dstRd, 1'b0,
			decodeCtrlPkg::aluRotr, 1'b0));
		ins = rInstr(mipsIsaPkg::opSpecial2, 5'd1, 5'd0, 5'd3, 5'd0, mipsIsaPkg::fnClz);
		decodeCheck(ins, aluCtrl(ins, 1'b1, 1'b1, decodeCtrlPkg::dstRd, 1'b0,
			decodeCtrlPkg::aluClz, 1'b0));
		ins = rInstr(mipsIsaPkg::opSpecial2, 5'd1, 5'd2, 5'd3, 5'd0, mipsIsaPkg::fnMul);
		decodeCheck(ins, aluCtrl(ins, 1'b1, 1'b1, decodeCtrlPkg::dstRd, 1'b0,
			decodeCtrlPkg::aluMul, 1'b1));
		ins = rInstr(mipsIsaPkg::opRType, 5'd1, 5'd2, 5'd0, 5'd0, mipsIsaPkg::fnMult);
		decodeCheck(ins, aluCtrl(ins, 1'b1, 1'b0, decodeCtrlPkg::dstRd, 1'b0,
			decodeCtrlPkg::aluRType, 1'b1));
	endtask

	task automatic memDecodeTest();
		mipsIsaPkg::word_t ins;
		decodeCtrlPkg::decodeCtrl_t exp;
		testName = "memDecode";
		ins = iInstr(mipsIsaPkg::opLw, 5'd8, 5'd9, 16'h0010);
		exp = aluCtrl(ins, 1'b1, 1'b1, decodeCtrlPkg::dstRt, 1'b1, decodeCtrlPkg::aluMem, 1'b0);
		exp.memRead = 1'b1;
		exp.memToReg = 1'b1;
		decodeCheck(ins, exp);
		checkWord("lw rsData", regVal[8], idEx.rsData);
		checkWord("lw rtData", regVal[9], idEx.rtData);
		ins = iInstr(mipsIsaPkg::opSw, 5'd12, 5'd11, 16'hfffc);
		exp = aluCtrl(ins, 1'b1, 1'b0, decodeCtrlPkg::dstRd, 1'b1, decodeCtrlPkg::aluMem, 1'b0);
		exp.memWrite = 1'b1;
		decodeCheck(ins, exp);
		checkWord("sw rsData", regVal[12], idEx.rsData);
		checkWord("sw rtData", regVal[11], idEx.rtData);
		checkWord("sw imm", 32'hffff_fffc, idEx.imm);
	endtask

	task automatic branchTest();
		mipsIsaPkg::word_t a;
		mipsIsaPkg::word_t b;
		mipsIsaPkg::word_t pc;
		mipsIsaPkg::word_t ins;
		mipsIsaPkg::word_t rnd;
		decodeCtrlPkg::decodeCtrl_t exp;
		testName = "branch";
		pc = 32'h0040_0200;
		a = $random(seed);
		b = $random(seed);
		if (b == a)
			b = ~a;
		rnd = $random(seed);
		writeReg(5'd1, a);
		writeReg(5'd2, a);
		writeReg(5'd3, b);
		writeReg(5'd4, a | 32'h8000_0000); // negative
		writeReg(5'd5, a & 32'h7fff_ffff);
		branchCheck(iInstr(mipsIsaPkg::opBeq, 5'd1, 5'd2, 16'hfff0), pc, 1'b1,
			brTarget(pc, 16'hfff0));
		branchCheck(iInstr(mipsIsaPkg::opBeq, 5'd1, 5'd3, 16'hfff0), pc, 1'b0, '0);
		branchCheck(iInstr(mipsIsaPkg::opBne, 5'd1, 5'd3, 16'h0020), pc, 1'b1,
			brTarget(pc, 16'h0020));
		branchCheck(iInstr(mipsIsaPkg::opBne, 5'd1, 5'd2, 16'h0020), pc, 1'b0, '0);
		branchCheck(iInstr(mipsIsaPkg::opRegimm, 5'd4, mipsIsaPkg::rtBltz, 16'h0100), pc, 1'b1,
			brTarget(pc, 16'h0100));
		branchCheck(iInstr(mipsIsaPkg::opRegimm, 5'd5, mipsIsaPkg::rtBltz, 16'h0100), pc, 1'b0, '0);
		branchCheck(iInstr(mipsIsaPkg::opRegimm, 5'd5, mipsIsaPkg::rtBgez, 16'h8004), pc, 1'b1,
			brTarget(pc, 16'h8004));
		branchCheck(iInstr(mipsIsaPkg::opRegimm, 5'd4, mipsIsaPkg::rtBgez, 16'h8004), pc, 1'b0, '0);
		ins = jInstr(mipsIsaPkg::opJ, rnd[25:0]);
		branchCheck(ins, pc, 1'b1, jumpTarget(pc, rnd[25:0]));
		ins = jInstr(mipsIsaPkg::opJal, rnd[25:0]);
		branchCheck(ins, pc, 1'b1, jumpTarget(pc, rnd[25:0]));
		capture();
		exp = aluCtrl(ins, 1'b1, 1'b1, decodeCtrlPkg::dstRa, 1'b0, decodeCtrlPkg::aluUseless, 1'b0);
		exp.jumpKind = decodeCtrlPkg::jmpDirect;
		checkCtrl("jal ctrl", exp, idEx.ctrl);
		ins = rInstr(mipsIsaPkg::opRType, 5'd6, 5'd0, 5'd0, 5'd0, mipsIsaPkg::fnJr);
		branchCheck(ins, pc, 1'b1, regVal[6]);
	endtask

	task automatic excTest();
		testName = "exceptions";
		excCheck(iInstr(6'b111111, 5'd1, 5'd2, 16'h0000), 4'b1000);
		excCheck(rInstr(mipsIsaPkg::opSpecial2, 5'd1, 5'd2, 5'd3, 5'd0, 6'b111111), 4'b1000);
		excCheck(iInstr(mipsIsaPkg::opRegimm, 5'd1, 5'b00111, 16'h0000), 4'b1000);
		excCheck(rInstr(mipsIsaPkg::opRType, 5'd0, 5'd0, 5'd0, 5'd0, mipsIsaPkg::fnSyscall), 4'b0010);
		excCheck(rInstr(mipsIsaPkg::opRType, 5'd0, 5'd0, 5'd0, 5'd0, mipsIsaPkg::fnBreak), 4'b0100);
		excCheck({mipsIsaPkg::opCop0, mipsIsaPkg::rsCo, 15'd0, mipsIsaPkg::fnEret}, 4'b0001);
		excCheck({mipsIsaPkg::opCop0, mipsIsaPkg::rsCo, 15'd1, mipsIsaPkg::fnEret}, 4'b1000);
	endtask

	task automatic pipelineTest();
		mipsIsaPkg::word_t addu;
		mipsIsaPkg::word_t lw;
		mipsIsaPkg::word_t pc;
		testName = "stall";
		pc = 32'h0040_0300;
		addu = rInstr(mipsIsaPkg::opRType, 5'd1, 5'd2, 5'd3, 5'd0, mipsIsaPkg::fnAddu);
		lw = iInstr(mipsIsaPkg::opLw, 5'd8, 5'd9, 16'h0010);
		issue(addu, pc);
		capture();
		@(posedge clk);
		stall <= 1'b1;
		instr <= lw;
		pcPlus4 <= pc + 32'd4;
		repeat (3) @(posedge clk);
		@(negedge clk);
		checkCtrl("held ctrl", aluCtrl(addu, 1'b1, 1'b1, decodeCtrlPkg::dstRd, 1'b0,
			decodeCtrlPkg::aluRType, 1'b0), idEx.ctrl);
		checkWord("held pcPlus4", pc, idEx.pcPlus4);
		checkWord("held rsData", regVal[1], idEx.rsData);
		@(posedge clk);
		stall <= 1'b0;
		capture();
		checkBit("memRead after release", 1'b1, idEx.ctrl.memRead);
		checkWord("pcPlus4 after release", pc + 32'd4, idEx.pcPlus4);

		testName = "flush";
		issue(lw, pc);
		capture();
		checkBit("valid before flush", 1'b1, idEx.valid);
		@(posedge clk);
		flush <= 1'b1;
		stall <= 1'b1; // flush wins over stall
		@(posedge clk);
		flush <= 1'b0;
		stall <= 1'b0;
		@(negedge clk);
		checkBubble();

		testName = "validLow";
		issue(iInstr(mipsIsaPkg::opBeq, 5'd1, 5'd2, 16'h0004), pc);
		checkBit("branchTaken valid", 1'b1, branchTaken);
		@(posedge clk);
		validIn <= 1'b0;
		@(negedge clk);
		checkBit("branchTaken invalid", 1'b0, branchTaken);
		capture();
		checkBubble();
	endtask

	task automatic regFileTest();
		mipsIsaPkg::word_t d;
		testName = "regFile";
		d = $random(seed);
		writeReg(5'd0, d | 32'd1);
		issue(rInstr(mipsIsaPkg::opRType, 5'd0, 5'd0, 5'd10, 5'd0, mipsIsaPkg::fnAddu), 32'h0040_0500);
		capture();
		checkWord("r0 rsData", '0, idEx.rsData);
		checkWord("r0 rtData", '0, idEx.rtData);
		d = $random(seed);
		if (d == regVal[7])
			d = ~d;
		// write r7 and read it in the same cycle
		@(posedge clk);
		wbWe <= 1'b1;
		wbAddr <= 5'd7;
		wbData <= d;
		validIn <= 1'b1;
		instr <= rInstr(mipsIsaPkg::opRType, 5'd7, 5'd7, 5'd10, 5'd0, mipsIsaPkg::fnAddu);
		@(posedge clk);
		wbWe <= 1'b0;
		regVal[7] = d;
		@(negedge clk);
		checkWord("bypass rsData", d, idEx.rsData);
		checkWord("bypass rtData", d, idEx.rtData);
	endtask

	initial begin
		seed = 32'h8a;
		arstN = 1'b0;
		validIn = 1'b0;
		instr = '0;
		pcPlus4 = '0;
		stall = 1'b0;
		flush = 1'b0;
		wbWe = 1'b0;
		wbAddr = '0;
		wbData = '0;
		repeat (5) @(posedge clk);
		arstN <= 1'b1;
		@(negedge clk);
		resetTest();
		fillRegs();
		aluDecodeTest();
		memDecodeTest();
		branchTest();
		excTest();
		pipelineTest();
		regFileTest();
		$display("SIMULATION PASSED");
		$finish;
	end
endmodule

// File: build.f
verilog/mipsIsaPkg.sv
verilog/decodeCtrlPkg.sv
verilog/mainDecoder.sv
verilog/regFile.sv
verilog/branchResolver.sv
verilog/decodeStage.sv
dv/decodeStage_asserts.sv
dv/decodeStageTb.sv

// File: run.sh
#!/bin/sh
# compile and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f build.f \
	--top-module decodeStageTb \
	-o decodeStageSim

./obj_dir/decodeStageSim
